//--- tb.f
pq_pkg.sv
free_slot_ring.sv
deq_req_fifo.sv
extreme_scan.sv
slot_store.sv
minmax_queue_top.sv
tb_minmax_queue.sv

//--- Makefile
TOP := tb_minmax_queue

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

//--- tb_minmax_queue.sv
`timescale 1ns/100ps

module tb_minmax_queue;

  localparam int MAX_ROWS     = 48;
  localparam int RESET_CYCLES = 10;
  localparam int ROW_CYCLES   = 3 * pq_pkg::DEPTH;

  typedef enum logic [2:0] {
    OP_ENQ,
    OP_DEQ_MIN,
    OP_DEQ_MAX,
    OP_BOTH,
    OP_WAIT
  } op_t;

  logic           clk_in;
  logic           rst_in;
  logic           enq_in;
  pq_pkg::tag_t   enq_tag_in;
  pq_pkg::data_t  enq_data_in;
  logic           deq_min_in;
  logic           deq_max_in;
  pq_pkg::data_t  data_out;
  pq_pkg::tag_t   tag_out;
  logic           valid_out;
  pq_pkg::count_t size_out;
  logic           empty_out;
  logic           full_out;
  pq_pkg::tag_t   max_tag_out;
  logic           idle_out;

  // operation table
  op_t           op_tab   [MAX_ROWS];
  pq_pkg::tag_t  tag_tab  [MAX_ROWS];
  pq_pkg::data_t data_tab [MAX_ROWS];
  string         name_tab [MAX_ROWS];
  int            num_rows = 0;

  // live entries as the client sees them
  pq_pkg::tag_t  model_tag  [pq_pkg::DEPTH];
  pq_pkg::data_t model_data [pq_pkg::DEPTH];
  logic          model_live [pq_pkg::DEPTH];
  int            model_count = 0;

  int cycle_count = 0;
  int cycle_limit = 1000000;

  minmax_queue_top minmax_queue_top_inst (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .enq_in      (enq_in),
    .enq_tag_in  (enq_tag_in),
    .enq_data_in (enq_data_in),
    .deq_min_in  (deq_min_in),
    .deq_max_in  (deq_max_in),
    .data_out    (data_out),
    .tag_out     (tag_out),
    .valid_out   (valid_out),
    .size_out    (size_out),
    .empty_out   (empty_out),
    .full_out    (full_out),
    .max_tag_out (max_tag_out),
    .idle_out    (idle_out)
  );

  always #4 clk_in = ~clk_in;

  always @(posedge clk_in) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Checks failed");
      $fatal(1, "run did not finish within %0d cycles", cycle_limit);
    end
  end

  task automatic add_row(input op_t op, input pq_pkg::tag_t tag, input pq_pkg::data_t data,
                         input string name);
    op_tab[num_rows]   = op;
    tag_tab[num_rows]  = tag;
    data_tab[num_rows] = data;
    name_tab[num_rows] = name;
    num_rows++;
  endtask

  // index of the smallest or largest live tag, -1 when empty
  function automatic int model_find(input logic want_max);
    int best;
    best = -1;
    for (int i = 0; i < pq_pkg::DEPTH; i++) begin
      if (model_live[i]) begin
        if (best < 0) begin
          best = i;
        end else if (want_max ? (model_tag[i] > model_tag[best])
                              : (model_tag[i] < model_tag[best])) begin
          best = i;
        end
      end
    end
    return best;
  endfunction

  function automatic pq_pkg::tag_t model_max_tag();
    int idx;
    idx = model_find(1'b1);
    return (idx < 0) ? pq_pkg::tag_t'(0) : model_tag[idx];
  endfunction

  function automatic void model_insert(input pq_pkg::tag_t tag, input pq_pkg::data_t data);
    int idx;
    idx = -1;
    for (int i = 0; i < pq_pkg::DEPTH; i++) begin
      if (!model_live[i] && idx < 0) begin
        idx = i;
      end
    end
    model_tag[idx]  = tag;
    model_data[idx] = data;
    model_live[idx] = 1'b1;
    model_count++;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("Checks failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic check_levels(input string name);
    check_value({name, " size"}, 32'(model_count), 32'(size_out));
    check_value({name, " empty"}, 32'(model_count == 0), 32'(empty_out));
    check_value({name, " full"}, 32'(model_count == pq_pkg::DEPTH), 32'(full_out));
  endtask

  task automatic step_cycle();
    @(posedge clk_in);
    #1;
  endtask

  task automatic apply_enqueue(input int r);
    logic accept;
    accept      = (model_count < pq_pkg::DEPTH);
    enq_in      = 1'b1;
    enq_tag_in  = tag_tab[r];
    enq_data_in = data_tab[r];
    step_cycle();
    enq_in = 1'b0;
    // an enqueue while full is ignored
    if (accept) begin
      model_insert(tag_tab[r], data_tab[r]);
    end
    check_levels(name_tab[r]);
    check_value({name_tab[r], " valid"}, 32'd0, 32'(valid_out));
  endtask

  task automatic apply_dequeue(input int r, input logic want_min, input logic want_max);
    int idx;
    int waited;
    idx        = model_find(!want_min);
    deq_min_in = want_min;
    deq_max_in = want_max;
    step_cycle();
    deq_min_in = 1'b0;
    deq_max_in = 1'b0;
    waited     = 1;
    if (idx < 0) begin
      // request on an empty queue is dropped silently
      while (waited < ROW_CYCLES) begin
        check_value({name_tab[r], " valid"}, 32'd0, 32'(valid_out));
        step_cycle();
        waited++;
      end
      check_value({name_tab[r], " valid"}, 32'd0, 32'(valid_out));
      check_value({name_tab[r], " idle"}, 32'd1, 32'(idle_out));
    end else begin
      while (!valid_out && waited < ROW_CYCLES) begin
        step_cycle();
        waited++;
      end
      assert (valid_out) else begin
        $display("Checks failed");
        $fatal(1, "%s: no dequeue output within %0d cycles", name_tab[r], ROW_CYCLES);
      end
      check_value({name_tab[r], " tag"}, 32'(model_tag[idx]), 32'(tag_out));
      check_value({name_tab[r], " data"}, model_data[idx], data_out);
      model_live[idx] = 1'b0;
      model_count--;
      check_value({name_tab[r], " size"}, 32'(model_count), 32'(size_out));
      step_cycle();
      check_value({name_tab[r], " pulse"}, 32'd0, 32'(valid_out));
    end
  endtask

  // long enough for a full sweep to publish
  task automatic apply_wait(input int r);
    repeat (pq_pkg::DEPTH + 2) begin
      step_cycle();
      check_value({name_tab[r], " valid"}, 32'd0, 32'(valid_out));
    end
    check_levels(name_tab[r]);
    check_value({name_tab[r], " idle"}, 32'd1, 32'(idle_out));
    check_value({name_tab[r], " max tag"}, 32'(model_max_tag()), 32'(max_tag_out));
  endtask

  task automatic build_table();
    add_row(OP_WAIT,    16'h0000, 32'h0000_0000, "reset_sweep");
    add_row(OP_ENQ,     16'h0120, 32'hA1B2_0001, "enq_a");
    add_row(OP_ENQ,     16'h0045, 32'h5EED_0002, "enq_b");
    add_row(OP_ENQ,     16'h0310, 32'hC0DE_0003, "enq_c");
    add_row(OP_ENQ,     16'h0088, 32'h0BAD_0004, "enq_d");
    add_row(OP_ENQ,     16'h0200, 32'hFACE_0005, "enq_e");
    add_row(OP_WAIT,    16'h0000, 32'h0000_0000, "fill_max");
    add_row(OP_DEQ_MIN, 16'h0000, 32'h0000_0000, "alt_min_1");
    add_row(OP_DEQ_MAX, 16'h0000, 32'h0000_0000, "alt_max_1");
    add_row(OP_DEQ_MIN, 16'h0000, 32'h0000_0000, "alt_min_2");
    add_row(OP_DEQ_MAX, 16'h0000, 32'h0000_0000, "alt_max_2");
    add_row(OP_ENQ,     16'h0050, 32'h1234_0006, "enq_f");
    add_row(OP_ENQ,     16'h0400, 32'h5678_0007, "enq_g");
    add_row(OP_BOTH,    16'h0000, 32'h0000_0000, "both_is_min");
    // fill up to DEPTH entries
    add_row(OP_ENQ,     16'h0011, 32'h9ABC_0008, "fill_1");
    add_row(OP_ENQ,     16'h0777, 32'hDEF0_0009, "fill_2");
    add_row(OP_ENQ,     16'h0099, 32'h1357_000A, "fill_3");
    add_row(OP_ENQ,     16'h0555, 32'h2468_000B, "fill_4");
    add_row(OP_ENQ,     16'h0033, 32'h3579_000C, "fill_5");
    add_row(OP_ENQ,     16'h0666, 32'h4680_000D, "fill_6");
    add_row(OP_ENQ,     16'h0001, 32'hFFFF_000E, "enq_when_full");
    add_row(OP_WAIT,    16'h0000, 32'h0000_0000, "full_max");
    add_row(OP_DEQ_MAX, 16'h0000, 32'h0000_0000, "full_deq_max");
    add_row(OP_DEQ_MIN, 16'h0000, 32'h0000_0000, "full_deq_min");
    // freed slots come back through the ring
    add_row(OP_ENQ,     16'h0002, 32'h7777_000F, "reuse_a");
    add_row(OP_ENQ,     16'h0800, 32'h8888_0010, "reuse_b");
    add_row(OP_DEQ_MIN, 16'h0000, 32'h0000_0000, "reuse_min");
    add_row(OP_DEQ_MAX, 16'h0000, 32'h0000_0000, "reuse_max");
    add_row(OP_DEQ_MIN, 16'h0000, 32'h0000_0000, "drain_1");
    add_row(OP_DEQ_MAX, 16'h0000, 32'h0000_0000, "drain_2");
    add_row(OP_DEQ_MIN, 16'h0000, 32'h0000_0000, "drain_3");
    add_row(OP_DEQ_MAX, 16'h0000, 32'h0000_0000, "drain_4");
    add_row(OP_DEQ_MIN, 16'h0000, 32'h0000_0000, "drain_5");
    add_row(OP_DEQ_MAX, 16'h0000, 32'h0000_0000, "drain_6");
    add_row(OP_DEQ_MIN, 16'h0000, 32'h0000_0000, "empty_min");
    add_row(OP_DEQ_MAX, 16'h0000, 32'h0000_0000, "empty_max");
    add_row(OP_WAIT,    16'h0000, 32'h0000_0000, "empty_wait");
    add_row(OP_ENQ,     16'h0123, 32'h9999_0011, "after_empty_enq");
    add_row(OP_DEQ_MAX, 16'h0000, 32'h0000_0000, "after_empty_deq");
    add_row(OP_WAIT,    16'h0000, 32'h0000_0000, "final_idle");
  endtask

  initial begin
    clk_in      = 1'b0;
    rst_in      = 1'b1;
    enq_in      = 1'b0;
    enq_tag_in  = '0;
    enq_data_in = '0;
    deq_min_in  = 1'b0;
    deq_max_in  = 1'b0;
    for (int i = 0; i < pq_pkg::DEPTH; i++) begin
      model_live[i] = 1'b0;
    end
    build_table();
    cycle_limit = num_rows * ROW_CYCLES + RESET_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk_in);
    #1;
    rst_in = 1'b0;
    check_levels("reset");
    check_value("reset idle", 32'd1, 32'(idle_out));
    check_value("reset valid", 32'd0, 32'(valid_out));

    for (int r = 0; r < num_rows; r++) begin
      case (op_tab[r])
        OP_ENQ:     apply_enqueue(r);
        OP_DEQ_MIN: apply_dequeue(r, 1'b1, 1'b0);
        OP_DEQ_MAX: apply_dequeue(r, 1'b0, 1'b1);
        OP_BOTH:    apply_dequeue(r, 1'b1, 1'b1);
        default:    apply_wait(r);
      endcase
    end

    $display("All checks passed");
    $finish;
  end

endmodule

//--- minmax_queue_top.sv
`timescale 1ns/100ps

module minmax_queue_top (
  input  logic           clk_in,
  input  logic           rst_in,
  input  logic           enq_in,
  input  pq_pkg::tag_t   enq_tag_in,
  input  pq_pkg::data_t  enq_data_in,
  input  logic           deq_min_in,
  input  logic           deq_max_in,
  output pq_pkg::data_t  data_out,
  output pq_pkg::tag_t   tag_out,
  output logic           valid_out,
  output pq_pkg::count_t size_out,
  output logic           empty_out,
  output logic           full_out,
  output pq_pkg::tag_t   max_tag_out,
  output logic           idle_out
);

  // free slot ring
  pq_pkg::slot_t free_slot;
  logic          free_avail;
  logic          take;
  logic          give;
  pq_pkg::slot_t give_slot;

  // request FIFO
  pq_pkg::req_kind_t head_kind;
  logic              head_valid;
  logic              pop;

  // scanner
  logic [pq_pkg::DEPTH*pq_pkg::TAG_W-1:0] tags_flat;
  logic [pq_pkg::DEPTH-1:0]               valid_flat;
  logic                                   changed;
  pq_pkg::slot_t                          min_slot;
  pq_pkg::slot_t                          max_slot;
  logic                                   scan_done;

  free_slot_ring free_slot_ring_inst (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .take       (take),
    .give       (give),
    .give_slot  (give_slot),
    .free_slot  (free_slot),
    .free_avail (free_avail)
  );

  deq_req_fifo deq_req_fifo_inst (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .deq_min_in (deq_min_in),
    .deq_max_in (deq_max_in),
    .pop        (pop),
    .head_kind  (head_kind),
    .head_valid (head_valid),
    .idle_out   (idle_out)
  );

  extreme_scan extreme_scan_inst (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .changed    (changed),
    .tags_flat  (tags_flat),
    .valid_flat (valid_flat),
    .min_slot   (min_slot),
    .max_slot   (max_slot),
    .max_tag    (max_tag_out),
    .scan_done  (scan_done)
  );

  slot_store slot_store_inst (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .enq_in      (enq_in),
    .enq_tag_in  (enq_tag_in),
    .enq_data_in (enq_data_in),
    .free_slot   (free_slot),
    .free_avail  (free_avail),
    .head_kind   (head_kind),
    .head_valid  (head_valid),
    .min_slot    (min_slot),
    .max_slot    (max_slot),
    .scan_done   (scan_done),
    .tags_flat   (tags_flat),
    .valid_flat  (valid_flat),
    .changed     (changed),
    .take        (take),
    .give        (give),
    .give_slot   (give_slot),
    .pop         (pop),
    .data_out    (data_out),
    .tag_out     (tag_out),
    .valid_out   (valid_out),
    .size_out    (size_out),
    .empty_out   (empty_out),
    .full_out    (full_out)
  );

endmodule

//--- slot_store.sv
`timescale 1ns/100ps

module slot_store (
  input  logic                                    clk_in,
  input  logic                                    rst_in,
  input  logic                                    enq_in,
  input  pq_pkg::tag_t                            enq_tag_in,
  input  pq_pkg::data_t                           enq_data_in,
  input  pq_pkg::slot_t                           free_slot,
  input  logic                                    free_avail,
  input  pq_pkg::req_kind_t                       head_kind,
  input  logic                                    head_valid,
  input  pq_pkg::slot_t                           min_slot,
  input  pq_pkg::slot_t                           max_slot,
  input  logic                                    scan_done,
  output logic [pq_pkg::DEPTH*pq_pkg::TAG_W-1:0]  tags_flat,
  output logic [pq_pkg::DEPTH-1:0]                valid_flat,
  output logic                                    changed,
  output logic                                    take,
  output logic                                    give,
  output pq_pkg::slot_t                           give_slot,
  output logic                                    pop,
  output pq_pkg::data_t                           data_out,
  output pq_pkg::tag_t                            tag_out,
  output logic                                    valid_out,
  output pq_pkg::count_t                          size_out,
  output logic                                    empty_out,
  output logic                                    full_out
);

  pq_pkg::tag_t              tag_mem  [pq_pkg::DEPTH];
  pq_pkg::data_t             data_mem [pq_pkg::DEPTH];
  logic [pq_pkg::DEPTH-1:0]  valid_q;
  pq_pkg::count_t            size_q;
  logic                      scan_fresh_q;

  logic                      enq_ok;
  logic                      scan_ok;
  logic                      consume;
  logic                      serve;
  pq_pkg::slot_t             sel_slot;

  // published extremes stay current from scan_done until the next change
  // a sweep that ends as the arrays move is already stale
  assign scan_ok = (scan_done && !changed) || scan_fresh_q;
  assign consume = head_valid && scan_ok;
  // head on an empty store is dropped
  assign serve   = consume && (size_q != '0);
  assign enq_ok  = enq_in && free_avail;

  assign sel_slot = (head_kind == pq_pkg::REQ_MIN) ? min_slot : max_slot;

  assign pop       = consume;
  assign take      = enq_ok;
  assign give      = serve;
  assign give_slot = sel_slot;

  assign size_out  = size_q;
  assign empty_out = (size_q == '0);
  assign full_out  = (size_q == pq_pkg::count_t'(pq_pkg::DEPTH)) || !free_avail;

  for (genvar g = 0; g < pq_pkg::DEPTH; g++) begin : g_flat
    assign tags_flat[g*pq_pkg::TAG_W +: pq_pkg::TAG_W] = tag_mem[g];
  end
  assign valid_flat = valid_q;

  // entry payload and dequeue output
  always_ff @(posedge clk_in) begin
    if (serve) begin
      data_out <= data_mem[sel_slot];
      tag_out  <= tag_mem[sel_slot];
    end
    if (enq_ok) begin
      tag_mem[free_slot]  <= enq_tag_in;
      data_mem[free_slot] <= enq_data_in;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid_q      <= '0;
      size_q       <= '0;
      valid_out    <= 1'b0;
      changed      <= 1'b0;
      scan_fresh_q <= 1'b0;
    end else begin
      valid_out <= serve;
      changed   <= enq_ok || serve;
      // served slot is valid and the free slot is not, so they never collide
      if (serve) begin
        valid_q[sel_slot] <= 1'b0;
      end
      if (enq_ok) begin
        valid_q[free_slot] <= 1'b1;
      end
      case ({enq_ok, serve})
        2'b10:   size_q <= size_q + 1'b1;
        2'b01:   size_q <= size_q - 1'b1;
        default: size_q <= size_q;
      endcase
      if (enq_ok || serve) begin
        scan_fresh_q <= 1'b0;
      end else if (scan_done && !changed) begin
        scan_fresh_q <= 1'b1;
      end
    end
  end

  // scanner must point at a live entry whenever a serve happens
  a_serve_from_valid : assert property (
    @(posedge clk_in) disable iff (rst_in)
    valid_out |-> $past(valid_q[sel_slot])
  );

  a_size_bound : assert property (
    @(posedge clk_in) disable iff (rst_in)
    size_q <= pq_pkg::count_t'(pq_pkg::DEPTH)
  );

endmodule

//--- extreme_scan.sv
`timescale 1ns/100ps

module extreme_scan (
  input  logic                                    clk_in,
  input  logic                                    rst_in,
  input  logic                                    changed,
  input  logic [pq_pkg::DEPTH*pq_pkg::TAG_W-1:0]  tags_flat,
  input  logic [pq_pkg::DEPTH-1:0]                valid_flat,
  output pq_pkg::slot_t                           min_slot,
  output pq_pkg::slot_t                           max_slot,
  output pq_pkg::tag_t                            max_tag,
  output logic                                    scan_done
);

  pq_pkg::scan_state_t state_q;
  pq_pkg::slot_t       idx_q;

  // running candidates for the current sweep
  pq_pkg::tag_t        cand_min_tag_q;
  pq_pkg::slot_t       cand_min_slot_q;
  pq_pkg::tag_t        cand_max_tag_q;
  pq_pkg::slot_t       cand_max_slot_q;

  pq_pkg::tag_t        cur_tag;
  logic                cur_valid;
  pq_pkg::tag_t        nxt_min_tag;
  pq_pkg::slot_t       nxt_min_slot;
  pq_pkg::tag_t        nxt_max_tag;
  pq_pkg::slot_t       nxt_max_slot;
  logic                last_visit;

  assign cur_tag   = tags_flat[idx_q*pq_pkg::TAG_W +: pq_pkg::TAG_W];
  assign cur_valid = valid_flat[idx_q];

  // fold the visited slot into the candidates
  always_comb begin
    nxt_min_tag  = cand_min_tag_q;
    nxt_min_slot = cand_min_slot_q;
    nxt_max_tag  = cand_max_tag_q;
    nxt_max_slot = cand_max_slot_q;
    if (cur_valid && (cur_tag <= cand_min_tag_q)) begin
      nxt_min_tag  = cur_tag;
      nxt_min_slot = idx_q;
    end
    if (cur_valid && (cur_tag >= cand_max_tag_q)) begin
      nxt_max_tag  = cur_tag;
      nxt_max_slot = idx_q;
    end
  end

  assign last_visit = (state_q == pq_pkg::SCAN_SWEEP) && (idx_q == pq_pkg::LAST_SLOT);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state_q         <= pq_pkg::SCAN_SWEEP;
      idx_q           <= '0;
      cand_min_tag_q  <= '1;
      cand_min_slot_q <= '0;
      cand_max_tag_q  <= '0;
      cand_max_slot_q <= '0;
      min_slot        <= '0;
      max_slot        <= '0;
      max_tag         <= '0;
      scan_done       <= 1'b0;
    end else begin
      scan_done <= 1'b0;
      if (changed) begin
        // arrays moved, start over from slot 0
        state_q         <= pq_pkg::SCAN_SWEEP;
        idx_q           <= '0;
        cand_min_tag_q  <= '1;
        cand_min_slot_q <= '0;
        cand_max_tag_q  <= '0;
        cand_max_slot_q <= '0;
      end else if (state_q == pq_pkg::SCAN_SWEEP) begin
        cand_min_tag_q  <= nxt_min_tag;
        cand_min_slot_q <= nxt_min_slot;
        cand_max_tag_q  <= nxt_max_tag;
        cand_max_slot_q <= nxt_max_slot;
        if (last_visit) begin
          // clean sweep, publish
          min_slot  <= nxt_min_slot;
          max_slot  <= nxt_max_slot;
          max_tag   <= nxt_max_tag;
          scan_done <= 1'b1;
          state_q   <= pq_pkg::SCAN_HOLD;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end
    end
  end

  // done only ever follows an uninterrupted visit of the last slot
  a_done_after_last : assert property (
    @(posedge clk_in) disable iff (rst_in)
    scan_done |-> $past(state_q == pq_pkg::SCAN_SWEEP && idx_q == pq_pkg::LAST_SLOT
                        && !changed)
  );

endmodule

//--- deq_req_fifo.sv
`timescale 1ns/100ps

module deq_req_fifo (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              deq_min_in,
  input  logic              deq_max_in,
  input  logic              pop,
  output pq_pkg::req_kind_t head_kind,
  output logic              head_valid,
  output logic              idle_out
);

  pq_pkg::req_kind_t              kind_mem [pq_pkg::REQ_DEPTH];
  logic [pq_pkg::REQ_PTR_W-1:0]   rd_ptr_q;
  logic [pq_pkg::REQ_PTR_W-1:0]   wr_ptr_q;
  logic [pq_pkg::REQ_CNT_W-1:0]   count_q;
  logic                           push;
  pq_pkg::req_kind_t              push_kind;
  logic                           full;
  logic                           push_ok;
  logic                           pop_ok;

  // min strobe wins when both arrive together
  assign push      = deq_min_in || deq_max_in;
  assign push_kind = deq_min_in ? pq_pkg::REQ_MIN : pq_pkg::REQ_MAX;

  assign full       = (count_q == pq_pkg::REQ_CNT_W'(pq_pkg::REQ_DEPTH));
  assign head_valid = (count_q != '0);
  assign idle_out   = (count_q == '0);
  assign head_kind  = kind_mem[rd_ptr_q];

  // extra requests are lost
  assign push_ok = push && !full;
  assign pop_ok  = pop && head_valid;

  always_ff @(posedge clk_in) begin
    if (push_ok) begin
      kind_mem[wr_ptr_q] <= push_kind;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == pq_pkg::REQ_LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == pq_pkg::REQ_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // store consumes only a real head
  a_pop_needs_head : assert property (
    @(posedge clk_in) disable iff (rst_in)
    pop |-> head_valid
  );

endmodule

//--- free_slot_ring.sv
`timescale 1ns/100ps

module free_slot_ring (
  input  logic          clk_in,
  input  logic          rst_in,
  input  logic          take,
  input  logic          give,
  input  pq_pkg::slot_t give_slot,
  output pq_pkg::slot_t free_slot,
  output logic          free_avail
);

  pq_pkg::slot_t              ring_q [pq_pkg::DEPTH];
  logic [pq_pkg::DEPTH-1:0]   ent_valid_q;
  pq_pkg::slot_t              rd_ptr_q;
  pq_pkg::slot_t              wr_ptr_q;
  logic                       take_ok;

  // oldest freed slot sits at the read pointer
  assign free_slot  = ring_q[rd_ptr_q];
  assign free_avail = ent_valid_q[rd_ptr_q];

  assign take_ok = take && free_avail;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      // every slot starts out free, in index order
      for (int i = 0; i < pq_pkg::DEPTH; i++) begin
        ring_q[i]      <= pq_pkg::slot_t'(i);
        ent_valid_q[i] <= 1'b1;
      end
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
    end else begin
      if (take_ok) begin
        ent_valid_q[rd_ptr_q] <= 1'b0;
        if (rd_ptr_q == pq_pkg::LAST_SLOT) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      // a returned slot lands after the take, so it wins on a shared entry
      if (give) begin
        ring_q[wr_ptr_q]      <= give_slot;
        ent_valid_q[wr_ptr_q] <= 1'b1;
        if (wr_ptr_q == pq_pkg::LAST_SLOT) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
    end
  end

  // the store only returns slots it took earlier
  a_no_give_when_full : assert property (
    @(posedge clk_in) disable iff (rst_in)
    give |-> (take || !(&ent_valid_q))
  );

endmodule

//--- pq_pkg.sv
package pq_pkg;

  // queue geometry
  localparam int DEPTH     = 8;
  localparam int REQ_DEPTH = 8;

  // payload widths
  localparam int TAG_W  = 16;
  localparam int DATA_W = 32;

  localparam int SLOT_W    = $clog2(DEPTH);
  localparam int REQ_PTR_W = $clog2(REQ_DEPTH);
  localparam int REQ_CNT_W = $clog2(REQ_DEPTH) + 1;

  // distance and point
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [SLOT_W-1:0]  slot_t;
  // 0 .. DEPTH entries
  typedef logic [SLOT_W:0]    count_t;

  localparam slot_t LAST_SLOT = slot_t'(DEPTH - 1);
  localparam logic [REQ_PTR_W-1:0] REQ_LAST = REQ_PTR_W'(REQ_DEPTH - 1);

  typedef enum logic {
    REQ_MIN,
    REQ_MAX
  } req_kind_t;

  typedef enum logic {
    SCAN_SWEEP,
    SCAN_HOLD
  } scan_state_t;

endpackage
